/* build.f */
+incdir+include
rtl/simd_pkg.sv
rtl/operand_stage.sv
rtl/lane_alu.sv
rtl/reduction_stage.sv
rtl/simd_unit.sv
test/simd_unit_tb.sv

/* include/simd_ref.svh */
// SIMD reference model
// expected lane and reduction values of the byte pipeline,
// computed with plain integer arithmetic

`ifndef SIMD_REF_SVH
`define SIMD_REF_SVH

function automatic int ref_clip(input int v, input bit uns, input bit sat);
    int hi;
    int lo;
    hi = uns ? UMAX : SMAX;
    lo = uns ? UMIN : SMIN;
    if (sat && v > hi)
        return hi;
    if (sat && v < lo)
        return lo;
    return v;
endfunction

function automatic wide_t ref_lane(input byte_t a, input byte_t b, input lane_op_t op,
                                   input bit uns, input bit sat);
    int x;
    int y;
    int r;
    x = uns ? int'(a) : int'($signed(a));
    y = uns ? int'(b) : int'($signed(b));
    case (op)
        OP_PASS: r = x;
        OP_ADD:  r = ref_clip(x + y, uns, sat);
        OP_SUB:  r = ref_clip(x - y, uns, sat);
        OP_MUL:  r = ref_clip(x * y, uns, sat);
        OP_MOVB: r = y;
        OP_MAX:  r = (x > y) ? x : y;
        OP_MIN:  r = (x > y) ? y : x;
        OP_AND:  r = int'(a & b);
        OP_OR:   r = int'(a | b);
        OP_XOR:  r = int'(a ^ b);
        OP_NAND: r = int'(byte_t'(~(a & b)));
        OP_NOR:  r = int'(byte_t'(~(a | b)));
        OP_XNOR: r = int'(byte_t'(~(a ^ b)));
        default: r = 0;
    endcase
    return r[15:0];
endfunction

function automatic word_t ref_result(input word_t ra, input word_t rb, input lane_op_t op,
                                     input red_op_t red, input bit uns, input bit sat);
    wide_t l;
    int    v;
    int    sum;
    int    mx;
    int    mn;
    word_t pack;
    byte_t xr;
    sum = 0;
    xr  = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
        l = ref_lane(ra[8*i +: 8], rb[8*i +: 8], op, uns, sat);
        v = uns ? int'(l) : int'($signed(l));
        if (i == 0 || v > mx)
            mx = v;
        if (i == 0 || v < mn)
            mn = v;
        sum = sum + v;
        xr  = xr ^ l[7:0];
        pack[8*i +: 8] = l[7:0];
    end
    case (red)
        RED_SUM: return word_t'(ref_clip(sum, uns, sat));
        RED_MAX: return word_t'(mx);
        RED_MIN: return word_t'(mn);
        RED_XOR: return {24'd0, xr};
        default: return pack;
    endcase
endfunction

`endif

/* test/simd_unit_tb.sv */
// SIMD byte pipeline testbench
// random lane and reduction operations, memory bypass and pipeline
// holds; a model of the stage-1 register feeds an expected-result
// queue that is checked whenever the result register advances

`default_nettype none

module simd_unit_tb
    import simd_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    `include "simd_ref.svh"

    // limit well above about 400 operations plus holds and drain
    localparam int NUM_OPS    = 400;
    localparam int MAX_CYCLES = 5 * NUM_OPS;

    logic       clk;
    logic       rstn;
    logic       holdn;
    word_t      ra;
    word_t      rb;
    lane_op_t   lane_op;
    red_op_t    red_op;
    logic       is_unsigned;
    logic       sat;
    logic       wen;
    word_t      bpv;
    logic [1:0] bp;
    word_t      result;
    logic       result_valid;

    int seed;
    int cycles;
    int value_errs;
    int other_errs;
    int issued;
    int checked;

    // copy of the operation sitting in stage 1
    word_t    m_ra;
    word_t    m_rb;
    lane_op_t m_op;
    red_op_t  m_red;
    logic     m_uns;
    logic     m_sat;
    logic     m_wen;
    int       m_adv;
    int       adv;

    word_t exp_q [$];
    int    issue_q [$];

    simd_unit dut_i (
        .clk          (clk),
        .rstn         (rstn),
        .holdn        (holdn),
        .ra           (ra),
        .rb           (rb),
        .lane_op      (lane_op),
        .red_op       (red_op),
        .is_unsigned  (is_unsigned),
        .sat          (sat),
        .wen          (wen),
        .bpv          (bpv),
        .bp           (bp),
        .result       (result),
        .result_valid (result_valid)
    );

    always #20 clk = ~clk;

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fffffff) % n;
    endfunction

    // drive one stimulus cycle just after the rising edge
    task automatic drive_cycle(input lane_op_t op, input red_op_t red,
                               input logic [1:0] bpsel, input logic hold,
                               input logic we);
        @(posedge clk);
        #1;
        ra          = $random(seed);
        rb          = $random(seed);
        bpv         = $random(seed);
        is_unsigned = 1'(rand_below(2));
        sat         = 1'(rand_below(2));
        lane_op     = op;
        red_op      = red;
        bp          = bpsel;
        holdn       = hold;
        wen         = we;
    endtask

    // expected results follow only the edges that advance the pipe
    always @(posedge clk) begin : model
        word_t exp_w;
        word_t a_w;
        word_t b_w;
        int    issue;
        if (!rstn) begin
            m_wen = 1'b0;
            adv   = 0;
        end else if (holdn) begin
            if (result_valid) begin
                assert (exp_q.size() != 0) else begin
                    other_errs++;
                    $display("result_valid high while no result was expected");
                end
                if (exp_q.size() != 0) begin
                    exp_w = exp_q.pop_front();
                    issue = issue_q.pop_front();
                    checked++;
                    assert (result == exp_w) else begin
                        value_errs++;
                        $display("ERR result expected %h actual %h", exp_w, result);
                    end
                    assert (adv == issue + 3) else begin
                        other_errs++;
                        $display("result took %0d advancing edges instead of 3",
                                 adv - issue);
                    end
                end
            end
            // bypass acts while the operation leaves stage 1
            if (m_wen) begin
                a_w = bp[0] ? bpv : m_ra;
                b_w = bp[1] ? bpv : m_rb;
                exp_q.push_back(ref_result(a_w, b_w, m_op, m_red, m_uns, m_sat));
                issue_q.push_back(m_adv);
            end
            m_ra  = ra;
            m_rb  = rb;
            m_op  = lane_op;
            m_red = red_op;
            m_uns = is_unsigned;
            m_sat = sat;
            m_wen = wen;
            m_adv = adv;
            if (wen)
                issued++;
            adv++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        seed        = 32'hdb2b6474;
        clk         = 1'b0;
        rstn        = 1'b0;
        holdn       = 1'b1;
        ra          = '0;
        rb          = '0;
        lane_op     = OP_PASS;
        red_op      = RED_NONE;
        is_unsigned = 1'b0;
        sat         = 1'b0;
        wen         = 1'b0;
        bpv         = '0;
        bp          = 2'b00;
        cycles      = 0;
        value_errs  = 0;
        other_errs  = 0;
        issued      = 0;
        checked     = 0;

        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;

        // idle after reset with nothing written
        repeat (3) begin
            @(posedge clk);
            #1;
            assert (result_valid == 1'b0) else begin
                value_errs++;
                $display("ERR result_valid expected %h actual %h", 1'b0, result_valid);
            end
            assert (result == '0) else begin
                value_errs++;
                $display("ERR result expected %h actual %h", 32'h0, result);
            end
        end

        // lane functions with packed low bytes
        for (int i = 0; i < 120; i++)
            drive_cycle(lane_op_t'(rand_below(13)), RED_NONE, 2'b00, 1'b1, 1'b1);

        // sum, max, min and xor reductions
        for (int i = 0; i < 120; i++)
            drive_cycle(lane_op_t'(rand_below(13)), red_op_t'(1 + rand_below(4)),
                        2'b00, 1'b1, 1'b1);

        // bypass of ra, rb or both
        for (int i = 0; i < 80; i++)
            drive_cycle(lane_op_t'(rand_below(13)), red_op_t'(rand_below(5)),
                        2'(rand_below(4)), 1'b1, 1'b1);

        // holds, unused opcodes and cycles with wen low
        for (int i = 0; i < 80; i++)
            drive_cycle(lane_op_t'(rand_below(16)), red_op_t'(rand_below(8)),
                        2'(rand_below(4)), rand_below(10) > 2, rand_below(4) != 0);

        // flush the last operations out of the pipe
        @(posedge clk);
        #1;
        wen   = 1'b0;
        bp    = 2'b00;
        holdn = 1'b1;
        repeat (5) @(posedge clk);
        while (exp_q.size() != 0)
            @(posedge clk);
        #1;

        assert (issued == checked) else begin
            other_errs++;
            $display("%0d operations written but %0d results seen", issued, checked);
        end

        $display("errors: %0d wrong values, %0d other failures, %0d results checked",
                 value_errs, other_errs, checked);
        if (value_errs == 0 && other_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/simd_unit.sv */
// SIMD byte pipeline top level
// operand stage, four byte-lane ALUs and the reduction stage;
// result appears three held-high cycles after its inputs

`default_nettype none

module simd_unit
    import simd_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       holdn,
    input  word_t      ra,
    input  word_t      rb,
    input  lane_op_t   lane_op,
    input  red_op_t    red_op,
    input  logic       is_unsigned,
    input  logic       sat,
    input  logic       wen,
    input  word_t      bpv,
    input  logic [1:0] bp,
    output word_t      result,
    output logic       result_valid
);

    byte_t    lane_a   [NUM_LANES];
    byte_t    lane_b   [NUM_LANES];
    wide_t    lane_res [NUM_LANES];
    lane_op_t s1_lane_op;
    red_op_t  s1_red_op;
    logic     s1_unsigned;
    logic     s1_sat;
    logic     s1_wen;

    operand_stage u_operand_stage (
        .clk         (clk),
        .rstn        (rstn),
        .holdn       (holdn),
        .ra          (ra),
        .rb          (rb),
        .bpv         (bpv),
        .bp          (bp),
        .lane_op     (lane_op),
        .red_op      (red_op),
        .is_unsigned (is_unsigned),
        .sat         (sat),
        .wen         (wen),
        .lane_a      (lane_a),
        .lane_b      (lane_b),
        .s1_lane_op  (s1_lane_op),
        .s1_red_op   (s1_red_op),
        .s1_unsigned (s1_unsigned),
        .s1_sat      (s1_sat),
        .s1_wen      (s1_wen)
    );

    // same opcode and signedness broadcast to every lane
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        lane_alu u_lane_alu (
            .clk         (clk),
            .rstn        (rstn),
            .holdn       (holdn),
            .a           (lane_a[i]),
            .b           (lane_b[i]),
            .lane_op     (s1_lane_op),
            .is_unsigned (s1_unsigned),
            .sat         (s1_sat),
            .lane_res    (lane_res[i])
        );
    end

    reduction_stage u_reduction_stage (
        .clk          (clk),
        .rstn         (rstn),
        .holdn        (holdn),
        .lane_res     (lane_res),
        .red_op       (s1_red_op),
        .is_unsigned  (s1_unsigned),
        .sat          (s1_sat),
        .wen          (s1_wen),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

/* rtl/reduction_stage.sv */
// SIMD reduction stage
// keeps the stage-2 control copy aligned with the lane register,
// folds the lane values into one word by sum, max, min, xor or
// packing, and registers the result with its valid strobe

`default_nettype none

module reduction_stage
    import simd_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  logic    holdn,
    input  wide_t   lane_res [NUM_LANES],
    input  red_op_t red_op,
    input  logic    is_unsigned,
    input  logic    sat,
    input  logic    wen,
    output word_t   result,
    output logic    result_valid
);

    red_op_t s2_red_op;
    logic    s2_unsigned;
    logic    s2_sat;
    logic    s2_wen;

    logic signed [31:0] lane_x [NUM_LANES];
    logic signed [31:0] sum_x;
    logic signed [31:0] sum_c;
    logic signed [31:0] max_x;
    logic signed [31:0] min_x;
    byte_t              xor_b;
    word_t              pack_w;
    word_t              res_d;

    // stage-2 control register
    always_ff @(posedge clk) begin
        if (!rstn) begin
            s2_red_op   <= RED_NONE;
            s2_unsigned <= 1'b0;
            s2_sat      <= 1'b0;
            s2_wen      <= 1'b0;
        end else if (holdn) begin
            s2_red_op   <= red_op;
            s2_unsigned <= is_unsigned;
            s2_sat      <= sat;
            s2_wen      <= wen;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (s2_unsigned)
                lane_x[i] = $signed({16'd0, lane_res[i]});
            else
                lane_x[i] = $signed({{16{lane_res[i][15]}}, lane_res[i]});
            pack_w[8*i +: 8] = lane_res[i][7:0];
        end

        sum_x = '0;
        max_x = lane_x[0];
        min_x = lane_x[0];
        xor_b = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            sum_x = sum_x + lane_x[i];
            xor_b = xor_b ^ lane_res[i][7:0];
            if (lane_x[i] > max_x)
                max_x = lane_x[i];
            if (lane_x[i] < min_x)
                min_x = lane_x[i];
        end

        // same clip bounds as the lanes
        sum_c = sum_x;
        if (s2_sat) begin
            if (sum_x > (s2_unsigned ? UMAX : SMAX))
                sum_c = s2_unsigned ? UMAX : SMAX;
            else if (sum_x < (s2_unsigned ? UMIN : SMIN))
                sum_c = s2_unsigned ? UMIN : SMIN;
        end

        case (s2_red_op)
            RED_SUM: res_d = sum_c;
            RED_MAX: res_d = max_x;
            RED_MIN: res_d = min_x;
            RED_XOR: res_d = {24'd0, xor_b};
            default: res_d = pack_w;
        endcase
    end

    // result register
    always_ff @(posedge clk) begin
        if (!rstn) begin
            result       <= '0;
            result_valid <= 1'b0;
        end else if (holdn) begin
            result       <= res_d;
            result_valid <= s2_wen;
        end
    end

endmodule

`default_nettype wire

/* rtl/lane_alu.sv */
// SIMD lane ALU
// element-wise arithmetic, multiply, max/min and bitwise logic on one
// byte lane, signed or unsigned, with optional clipping to 8 bits;
// the 16-bit lane value is held in the stage-2 lane register

`default_nettype none

module lane_alu
    import simd_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     holdn,
    input  byte_t    a,
    input  byte_t    b,
    input  lane_op_t lane_op,
    input  logic     is_unsigned,
    input  logic     sat,
    output wide_t    lane_res
);

    // 18 bits hold every exact result, 255 * 255 included
    logic signed [17:0] xa;
    logic signed [17:0] xb;
    logic signed [17:0] add_x;
    logic signed [17:0] sub_x;
    logic signed [17:0] mul_x;
    wide_t              res_d;

    // clip to the 8-bit range of the chosen reading, or truncate
    function automatic wide_t clip(input logic signed [17:0] v,
                                   input logic uns,
                                   input logic en);
        int    hi;
        int    lo;
        wide_t r;
        hi = uns ? UMAX : SMAX;
        lo = uns ? UMIN : SMIN;
        r  = v[15:0];
        if (en) begin
            if (v > hi)
                r = hi[15:0];
            else if (v < lo)
                r = lo[15:0];
        end
        return r;
    endfunction

    // operands read as signed or unsigned
    assign xa = is_unsigned ? $signed({10'd0, a}) : $signed({{10{a[7]}}, a});
    assign xb = is_unsigned ? $signed({10'd0, b}) : $signed({{10{b[7]}}, b});

    assign add_x = xa + xb;
    assign sub_x = xa - xb;
    assign mul_x = xa * xb;

    always_comb begin
        case (lane_op)
            OP_PASS: res_d = xa[15:0];
            OP_ADD:  res_d = clip(add_x, is_unsigned, sat);
            OP_SUB:  res_d = clip(sub_x, is_unsigned, sat);
            OP_MUL:  res_d = clip(mul_x, is_unsigned, sat);
            OP_MOVB: res_d = xb[15:0];
            OP_MAX:  res_d = (xa > xb) ? xa[15:0] : xb[15:0];
            OP_MIN:  res_d = (xa > xb) ? xb[15:0] : xa[15:0];
            // logic results are always zero-extended
            OP_AND:  res_d = {8'h00, a & b};
            OP_OR:   res_d = {8'h00, a | b};
            OP_XOR:  res_d = {8'h00, a ^ b};
            OP_NAND: res_d = {8'h00, ~(a & b)};
            OP_NOR:  res_d = {8'h00, ~(a | b)};
            OP_XNOR: res_d = {8'h00, ~(a ^ b)};
            default: res_d = '0;
        endcase
    end

    // stage-2 lane register
    always_ff @(posedge clk) begin
        if (!rstn)
            lane_res <= '0;
        else if (holdn)
            lane_res <= res_d;
    end

endmodule

`default_nettype wire

/* rtl/operand_stage.sv */
// SIMD operand stage
// registers operand words and opcode fields, applies the memory
// bypass while the operation sits in stage 1, and splits the
// selected words into byte lanes

`default_nettype none

module operand_stage
    import simd_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     holdn,
    input  word_t    ra,
    input  word_t    rb,
    input  word_t    bpv,
    input  logic [1:0] bp,
    input  lane_op_t lane_op,
    input  red_op_t  red_op,
    input  logic     is_unsigned,
    input  logic     sat,
    input  logic     wen,
    output byte_t    lane_a [NUM_LANES],
    output byte_t    lane_b [NUM_LANES],
    output lane_op_t s1_lane_op,
    output red_op_t  s1_red_op,
    output logic     s1_unsigned,
    output logic     s1_sat,
    output logic     s1_wen
);

    word_t s1_ra;
    word_t s1_rb;
    word_t op_a;
    word_t op_b;

    // stage-1 register
    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1_ra       <= '0;
            s1_rb       <= '0;
            s1_lane_op  <= OP_PASS;
            s1_red_op   <= RED_NONE;
            s1_unsigned <= 1'b0;
            s1_sat      <= 1'b0;
            s1_wen      <= 1'b0;
        end else if (holdn) begin
            s1_ra       <= ra;
            s1_rb       <= rb;
            s1_lane_op  <= lane_op;
            s1_red_op   <= red_op;
            s1_unsigned <= is_unsigned;
            s1_sat      <= sat;
            s1_wen      <= wen;
        end
    end

    // bypass word arrives from memory in this cycle, not registered
    assign op_a = bp[0] ? bpv : s1_ra;
    assign op_b = bp[1] ? bpv : s1_rb;

    // lane 0 takes the low byte
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_a[i] = op_a[8*i +: 8];
            lane_b[i] = op_b[8*i +: 8];
        end
    end

endmodule

`default_nettype wire

/* rtl/simd_pkg.sv */
// SIMD byte pipeline package
// lane count, vector types, lane and reduction opcodes, clip bounds
// shared by every stage of the pipeline and by the reference model

`default_nettype none

package simd_pkg;

    // number of byte lanes in a word
    localparam int NUM_LANES = 4;

    // one lane operand
    typedef logic [7:0]  byte_t;
    // one lane result, two's complement
    typedef logic [15:0] wide_t;
    // operand, bypass and result word
    typedef logic [31:0] word_t;

    // element-wise function code
    typedef logic [3:0] lane_op_t;
    // cross-lane reduction code
    typedef logic [2:0] red_op_t;

    // lane opcodes
    localparam lane_op_t OP_PASS = 4'd0;
    localparam lane_op_t OP_ADD  = 4'd1;
    localparam lane_op_t OP_SUB  = 4'd2;
    localparam lane_op_t OP_MUL  = 4'd3;
    localparam lane_op_t OP_MOVB = 4'd4;
    localparam lane_op_t OP_MAX  = 4'd5;
    localparam lane_op_t OP_MIN  = 4'd6;
    localparam lane_op_t OP_AND  = 4'd7;
    localparam lane_op_t OP_OR   = 4'd8;
    localparam lane_op_t OP_XOR  = 4'd9;
    localparam lane_op_t OP_NAND = 4'd10;
    localparam lane_op_t OP_NOR  = 4'd11;
    localparam lane_op_t OP_XNOR = 4'd12;

    // reduction opcodes, 5 to 7 fall back to packing
    localparam red_op_t RED_NONE = 3'd0;
    localparam red_op_t RED_SUM  = 3'd1;
    localparam red_op_t RED_MAX  = 3'd2;
    localparam red_op_t RED_MIN  = 3'd3;
    localparam red_op_t RED_XOR  = 3'd4;

    // clipping bounds
    localparam int SMAX = 127;
    localparam int SMIN = -128;
    localparam int UMAX = 255;
    localparam int UMIN = 0;

endpackage

`default_nettype wire
